// File: vec_pkg.sv
// Shared constants for the vector slice
// Element width and opcode enums
// Stage structs and the bank word union

package vec_pkg;

    // Lanes match the four banks, one 32-bit word each
    localparam int LANE_COUNT = 4;
    // Register count follows the 5-bit register fields
    localparam int VREG_COUNT = 32;
    // Bytes per register, four banks of four bytes
    localparam int VREG_BYTES = 16;

    // Encoded as log2 of the element byte count
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_t;

    typedef enum logic [2:0] {
        VADD = 3'd0,
        VSUB = 3'd1,
        VAND = 3'd2,
        VOR  = 3'd3,
        VXOR = 3'd4
    } vop_t;

    // One bank word, decoded by element width
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
        logic [31:0]      w;
    } lane_word_u;

    // Instruction held by decode for the generator
    typedef struct packed {
        vop_t       op;
        logic [4:0] vd;
        logic [4:0] vs1;
        logic [4:0] vs2;
        sew_t       eew;
        logic [7:0] vl;
    } vinstr_t;

    // One micro-op of up to four elements
    typedef struct packed {
        logic       valid;
        logic       last;
        vop_t       op;
        logic [4:0] vd;
        logic [4:0] vs1;
        logic [4:0] vs2;
        sew_t       eew;
        logic [2:0] reg_offset;
        logic [1:0] bank_offset;
        logic [3:0] lane_active;
    } vuop_t;

    // Micro-op with both source registers read
    typedef struct packed {
        vuop_t                        uop;
        lane_word_u [LANE_COUNT-1:0]  src1;
        lane_word_u [LANE_COUNT-1:0]  src2;
    } vread_t;

    // Write-back, byte enable bit 4*lane+byte
    typedef struct packed {
        logic                         valid;
        logic                         last;
        logic [4:0]                   vreg;
        lane_word_u [LANE_COUNT-1:0]  data;
        logic [VREG_BYTES-1:0]        be;
    } vwrite_t;

endpackage

// File: vec_decode.sv
// Configuration register for vl and element width
// Instruction latch and the gen level for the generator

`timescale 1ns/100ps

module vec_decode (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            cfg_we,
    input  logic [7:0]      cfg_vl,
    input  vec_pkg::sew_t   cfg_eew,
    input  logic            issue,
    input  vec_pkg::vop_t   instr_op,
    input  logic [4:0]      instr_vd,
    input  logic [4:0]      instr_vs1,
    input  logic [4:0]      instr_vs2,
    input  logic            gen_last,
    output vec_pkg::vinstr_t instr,
    output logic            gen
);

    import vec_pkg::*;

    logic [7:0] vl_q;
    sew_t       eew_q;
    logic       accept;

    // New instruction only while the generator is idle
    assign accept = issue && !gen;

    // Vector configuration, written by the host strobe
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vl_q  <= '0;
            eew_q <= SEW8;
        end else if (cfg_we) begin
            vl_q  <= cfg_vl;
            eew_q <= cfg_eew;
        end
    end

    // Instruction fields plus the config in force at issue
    always_ff @(posedge CLK) begin
        if (accept) begin
            instr <= '{op: instr_op, vd: instr_vd, vs1: instr_vs1, vs2: instr_vs2,
                       eew: eew_q, vl: vl_q};
        end
    end

    // High from the edge after issue until the last micro-op goes out
    // Stall is already folded into gen_last
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            gen <= 1'b0;
        end else if (accept) begin
            gen <= 1'b1;
        end else if (gen_last) begin
            gen <= 1'b0;
        end
    end

endmodule

// File: vec_uop_gen.sv
// Micro-op generator for element-wise vector ops
// Micro-op counter and elements-left tracking
// Register offset, bank offset and lane mask per micro-op

`timescale 1ns/100ps

module vec_uop_gen (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             stall,
    input  logic             gen,
    input  vec_pkg::vinstr_t instr,
    output vec_pkg::vuop_t   uop,
    output logic             gen_last
);

    import vec_pkg::*;

    // Counters loaded for the current instruction
    logic       loaded;
    logic       refresh;
    logic       advance;
    logic       last;

    // Micro-op number, at most 32 micro-ops per group
    logic [4:0] uop_num;
    // Elements still to go, including this micro-op
    logic [7:0] elems_left;
    logic [3:0] bank_shift;

    // First free cycle of gen loads the counters, no micro-op yet
    assign refresh = gen && !loaded && !stall;
    // Micro-op goes out on every free cycle after that
    assign advance = gen && loaded && !stall;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            loaded <= 1'b0;
        end else if (refresh) begin
            loaded <= 1'b1;
        end else if (gen_last) begin
            loaded <= 1'b0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            uop_num <= '0;
        end else if (refresh) begin
            uop_num <= '0;
        end else if (advance) begin
            uop_num <= uop_num + 5'd1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            elems_left <= '0;
        end else if (refresh) begin
            elems_left <= instr.vl;
        end else if (advance) begin
            elems_left <= elems_left - 8'(LANE_COUNT);
        end
    end

    // Four or fewer elements means this is the final micro-op
    assign last     = (elems_left <= 8'(LANE_COUNT));
    assign gen_last = advance && last;

    // Byte position of the element inside each bank word
    assign bank_shift = {2'b00, uop_num[1:0]} << instr.eew;

    always_comb begin
        uop.valid       = advance;
        uop.last        = last;
        uop.op          = instr.op;
        uop.vd          = instr.vd;
        uop.vs1         = instr.vs1;
        uop.vs2         = instr.vs2;
        uop.eew         = instr.eew;
        uop.bank_offset = bank_shift[1:0];

        // Micro-op number divided by elements per bank word
        case (instr.eew)
            SEW8:    uop.reg_offset = uop_num[4:2];
            SEW16:   uop.reg_offset = uop_num[3:1];
            SEW32:   uop.reg_offset = uop_num[2:0];
            default: uop.reg_offset = '0;
        endcase

        // Partial final micro-op
        case (elems_left)
            8'd1:    uop.lane_active = 4'b0001;
            8'd2:    uop.lane_active = 4'b0011;
            8'd3:    uop.lane_active = 4'b0111;
            default: uop.lane_active = 4'b1111;
        endcase
    end

endmodule

// File: vec_regfile.sv
// Four-bank vector register file
// Source read stage for micro-ops
// Byte-enabled write-back, host word port and done strobe

`timescale 1ns/100ps

module vec_regfile (
    input  logic             CLK,
    input  logic             nRST,
    input  vec_pkg::vuop_t   uop,
    input  vec_pkg::vwrite_t wb,
    input  logic             host_we,
    input  logic [4:0]       host_reg,
    input  logic [1:0]       host_bank,
    input  logic [31:0]      host_wdata,
    output vec_pkg::vread_t  rd,
    output logic [31:0]      host_rdata,
    output logic             done
);

    import vec_pkg::*;

    // One entry per register, one word per bank
    lane_word_u [LANE_COUNT-1:0] vreg_mem [VREG_COUNT];

    logic [4:0] rs1_idx;
    logic [4:0] rs2_idx;
    vread_t     rd_q;
    logic       rd_valid;

    // Register within the group, wraps at 32
    assign rs1_idx = uop.vs1 + 5'(uop.reg_offset);
    assign rs2_idx = uop.vs2 + 5'(uop.reg_offset);

    // Read stage payload
    always_ff @(posedge CLK) begin
        rd_q.uop  <= uop;
        rd_q.src1 <= vreg_mem[rs1_idx];
        rd_q.src2 <= vreg_mem[rs2_idx];
    end

    // Valid bit of the read stage
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= uop.valid;
        end
    end

    always_comb begin
        rd           = rd_q;
        rd.uop.valid = rd_valid;
    end

    // Host word write wins, never both in one cycle
    always_ff @(posedge CLK) begin
        if (host_we) begin
            vreg_mem[host_reg][host_bank].w <= host_wdata;
        end else if (wb.valid) begin
            for (int l = 0; l < LANE_COUNT; l++) begin
                for (int k = 0; k < 4; k++) begin
                    // Only bytes of active elements
                    if (wb.be[l*4 + k]) begin
                        vreg_mem[wb.vreg][l].b[k] <= wb.data[l].b[k];
                    end
                end
            end
        end
    end

    // Host read port
    assign host_rdata = vreg_mem[host_reg][host_bank].w;

    // Final write of the instruction lands on this edge
    assign done = wb.valid && wb.last;

endmodule

// File: vec_lane_alu.sv
// Four-lane element ALU
// Element extract by width and bank offset, op, result insert
// Write-back byte enables from lane mask and width

`timescale 1ns/100ps

module vec_lane_alu (
    input  logic             CLK,
    input  logic             nRST,
    input  vec_pkg::vread_t  rd,
    output vec_pkg::vwrite_t wb
);

    import vec_pkg::*;

    vwrite_t wb_next;
    vwrite_t wb_q;
    logic    wb_valid;

    // One lane, vd = vs2 op vs1, rest of the word from vs2
    function automatic lane_word_u lane_calc(
        input vop_t       op,
        input sew_t       eew,
        input logic [1:0] boff,
        input lane_word_u va,
        input lane_word_u vb
    );
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        lane_word_u  res;

        // Zero-extended element fields
        case (eew)
            SEW8: begin
                a = {24'd0, va.b[boff]};
                b = {24'd0, vb.b[boff]};
            end
            SEW16: begin
                a = {16'd0, va.h[boff[1]]};
                b = {16'd0, vb.h[boff[1]]};
            end
            default: begin
                a = va.w;
                b = vb.w;
            end
        endcase

        case (op)
            VADD:    r = b + a;
            VSUB:    r = b - a;
            VAND:    r = b & a;
            VOR:     r = b | a;
            VXOR:    r = b ^ a;
            default: r = '0;
        endcase

        // Truncation here gives wrap-around at the element width
        res = vb;
        case (eew)
            SEW8:    res.b[boff] = r[7:0];
            SEW16:   res.h[boff[1]] = r[15:0];
            default: res.w = r;
        endcase
        return res;
    endfunction

    // Bytes covered by one element
    function automatic logic [3:0] lane_be(input sew_t eew, input logic [1:0] boff);
        case (eew)
            SEW8:    return 4'b0001 << boff;
            SEW16:   return 4'b0011 << boff;
            default: return 4'b1111;
        endcase
    endfunction

    always_comb begin
        wb_next.valid = rd.uop.valid;
        wb_next.last  = rd.uop.last;
        wb_next.vreg  = rd.uop.vd + 5'(rd.uop.reg_offset);
        for (int l = 0; l < LANE_COUNT; l++) begin
            wb_next.data[l] = lane_calc(rd.uop.op, rd.uop.eew, rd.uop.bank_offset,
                                        rd.src1[l], rd.src2[l]);
            // Tail lanes keep their bytes
            wb_next.be[l*4 +: 4] = rd.uop.lane_active[l] ?
                                   lane_be(rd.uop.eew, rd.uop.bank_offset) : 4'b0000;
        end
    end

    always_ff @(posedge CLK) begin
        wb_q <= wb_next;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= wb_next.valid;
        end
    end

    always_comb begin
        wb       = wb_q;
        wb.valid = wb_valid;
    end

endmodule

// File: vec_unit_top.sv
// Vector execution slice top level
// Decode, micro-op generator, register file and lane ALU
// Busy level for the host

`timescale 1ns/100ps

module vec_unit_top (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            cfg_we,
    input  logic [7:0]      cfg_vl,
    input  vec_pkg::sew_t   cfg_eew,
    input  logic            issue,
    input  vec_pkg::vop_t   instr_op,
    input  logic [4:0]      instr_vd,
    input  logic [4:0]      instr_vs1,
    input  logic [4:0]      instr_vs2,
    input  logic            stall,
    input  logic            host_we,
    input  logic [4:0]      host_reg,
    input  logic [1:0]      host_bank,
    input  logic [31:0]     host_wdata,
    output logic [31:0]     host_rdata,
    output logic            busy,
    output logic            done
);

    import vec_pkg::*;

    vinstr_t instr;
    vuop_t   uop;
    vread_t  rd;
    vwrite_t wb;
    logic    gen;
    logic    gen_last;
    logic    busy_q;

    vec_decode i_vec_decode (
        .CLK, .nRST, .cfg_we, .cfg_vl, .cfg_eew, .issue, .instr_op,
        .instr_vd, .instr_vs1, .instr_vs2, .gen_last, .instr, .gen
    );

    // Stall only holds the generator, later stages keep draining
    vec_uop_gen i_vec_uop_gen (.CLK, .nRST, .stall, .gen, .instr, .uop, .gen_last);

    vec_regfile i_vec_regfile (
        .CLK, .nRST, .uop, .wb, .host_we, .host_reg, .host_bank,
        .host_wdata, .rd, .host_rdata, .done
    );

    vec_lane_alu i_vec_lane_alu (.CLK, .nRST, .rd, .wb);

    // Set by an accepted issue, cleared by done
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_q <= 1'b0;
        end else if (issue && !busy) begin
            busy_q <= 1'b1;
        end else if (done) begin
            busy_q <= 1'b0;
        end
    end

    // Drops already in the done cycle
    assign busy = busy_q && !done;

endmodule

// File: vec_unit_props.sv
// Concurrent checks on the micro-op generator
// Bound into every vec_uop_gen instance

`timescale 1ns/100ps

module vec_unit_props (
    input logic             CLK,
    input logic             nRST,
    input logic             stall,
    input logic             gen,
    input vec_pkg::vinstr_t instr,
    input vec_pkg::vuop_t   uop,
    input logic             gen_last
);

    // Running count of failed checks
    int assert_fails = 0;

    logic [3:0] tail_lanes;

    // Active lanes of the final micro-op from vl alone
    assign tail_lanes = (instr.vl[1:0] == 2'd0) ? 4'b1111
                                                 : (4'b0001 << instr.vl[1:0]) - 4'b0001;

    // Final micro-op carries the vl tail and earlier ones all four lanes
    a_lane_active: assert property (@(posedge CLK) disable iff (!nRST)
        uop.valid |-> (uop.lane_active == (uop.last ? tail_lanes : 4'b1111)))
    else begin
        $error("lane mask of a valid micro-op does not match vl");
        assert_fails++;
    end

    // Stall gives a bubble and freezes the micro-op fields
    a_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (gen && stall) |-> !uop.valid ##1
        $stable({uop.last, uop.reg_offset, uop.bank_offset, uop.lane_active}))
    else begin
        $error("micro-op changed or went valid under stall");
        assert_fails++;
    end

    // gen_last ends the gen window, one per instruction
    a_last_once: assert property (@(posedge CLK) disable iff (!nRST)
        gen_last |-> gen ##1 !gen)
    else begin
        $error("gen_last outside gen or gen still high after it");
        assert_fails++;
    end

    a_gen_end: assert property (@(posedge CLK) disable iff (!nRST)
        $fell(gen) |-> $past(gen_last))
    else begin
        $error("gen dropped without gen_last");
        assert_fails++;
    end

endmodule

bind vec_uop_gen vec_unit_props i_vec_unit_props (
    .CLK, .nRST, .stall, .gen, .instr, .uop, .gen_last
);

// File: tb_vec_unit.sv
// Testbench for the vector execution slice
// Case table, register file model, preload and full readback

`timescale 1ns/100ps

module tb_vec_unit;

    import vec_pkg::*;

    localparam int DONE_TIMEOUT = 2000;

    typedef struct {
        string name;
        vop_t  op;
        sew_t  eew;
        int    vl;
        int    vd;
        int    vs1;
        int    vs2;
        bit    use_stall;
    } case_t;

    logic        CLK;
    logic        nRST;
    logic        cfg_we;
    logic [7:0]  cfg_vl;
    sew_t        cfg_eew;
    logic        issue;
    vop_t        instr_op;
    logic [4:0]  instr_vd;
    logic [4:0]  instr_vs1;
    logic [4:0]  instr_vs2;
    logic        stall;
    logic        host_we;
    logic [4:0]  host_reg;
    logic [1:0]  host_bank;
    logic [31:0] host_wdata;
    logic [31:0] host_rdata;
    logic        busy;
    logic        done;

    // Expected register file contents
    logic [31:0] model [VREG_COUNT][LANE_COUNT];
    case_t       cases [11];

    vec_unit_top i_vec_unit_top (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Bank, bit shift and register of element e in the group at base
    task automatic element_place(input sew_t eew, input int base, input int e,
                                 output int vreg, output int bank, output int shift);
        int s;
        int per_word;
        s        = 1 << eew;
        per_word = 4 / s;
        bank     = e % 4;
        shift    = ((e / 4) % per_word) * s * 8;
        vreg     = (base + (e / 4) / per_word) % VREG_COUNT;
    endtask

    // vd = vs2 op vs1
    function automatic logic [31:0] op_result(input vop_t op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            VADD:    return b + a;
            VSUB:    return b - a;
            VAND:    return b & a;
            VOR:     return b | a;
            default: return b ^ a;
        endcase
    endfunction

    task automatic apply_model(input case_t tc);
        logic [31:0] src [VREG_COUNT][LANE_COUNT];
        logic [31:0] mask;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        int          vreg;
        int          bank;
        int          shift;
        // Sources from the snapshot, so vd overlap stays element-wise
        src  = model;
        mask = (tc.eew == SEW32) ? 32'hffff_ffff : ((32'd1 << (8 << tc.eew)) - 32'd1);
        for (int e = 0; e < tc.vl; e++) begin
            element_place(tc.eew, tc.vs1, e, vreg, bank, shift);
            a = (src[vreg][bank] >> shift) & mask;
            element_place(tc.eew, tc.vs2, e, vreg, bank, shift);
            b = (src[vreg][bank] >> shift) & mask;
            // Truncate to element width
            r = op_result(tc.op, a, b) & mask;
            element_place(tc.eew, tc.vd, e, vreg, bank, shift);
            model[vreg][bank] = (model[vreg][bank] & ~(mask << shift)) | (r << shift);
        end
    endtask

    task automatic preload_regs();
        logic [31:0] word;
        for (int r = 0; r < VREG_COUNT; r++) begin
            for (int b = 0; b < LANE_COUNT; b++) begin
                word        = $urandom();
                model[r][b] = word;
                @(posedge CLK);
                host_we    <= 1'b1;
                host_reg   <= 5'(r);
                host_bank  <= 2'(b);
                host_wdata <= word;
            end
        end
        @(posedge CLK);
        host_we <= 1'b0;
    endtask

    task automatic issue_case(input case_t tc);
        @(posedge CLK);
        cfg_we  <= 1'b1;
        cfg_vl  <= 8'(tc.vl);
        cfg_eew <= tc.eew;
        @(posedge CLK);
        cfg_we    <= 1'b0;
        issue     <= 1'b1;
        instr_op  <= tc.op;
        instr_vd  <= 5'(tc.vd);
        instr_vs1 <= 5'(tc.vs1);
        instr_vs2 <= 5'(tc.vs2);
        @(posedge CLK);
        issue <= 1'b0;
        @(negedge CLK);
        compare_value({tc.name, " busy after issue"}, 32'd1, 32'(busy));
    endtask

    // Random stall while waiting, when the case asks for it
    task automatic wait_done(input case_t tc);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(posedge CLK);
            stall <= tc.use_stall ? 1'($urandom() % 2) : 1'b0;
            @(negedge CLK);
            seen = done;
            cycles++;
        end
        if (!seen) begin
            $display("Timeout waiting for done in %s", tc.name);
            $display("Some tests failed");
            $fatal(1, "no done");
        end
        compare_value({tc.name, " busy at done"}, 32'd0, 32'(busy));
        @(posedge CLK);
        stall <= 1'b0;
    endtask

    task automatic read_back(input string name);
        for (int r = 0; r < VREG_COUNT; r++) begin
            for (int b = 0; b < LANE_COUNT; b++) begin
                @(posedge CLK);
                host_reg  <= 5'(r);
                host_bank <= 2'(b);
                @(negedge CLK);
                compare_value($sformatf("%s v%0d bank %0d", name, r, b), model[r][b],
                              host_rdata);
            end
        end
    endtask

    task automatic build_table();
        cases[0]  = '{"full32_add",  VADD, SEW32,  8,  4, 12, 20, 1'b0};
        cases[1]  = '{"part32_sub",  VSUB, SEW32,  7,  8, 16, 24, 1'b0};
        cases[2]  = '{"pack8_add",   VADD, SEW8,  45,  0,  8, 16, 1'b0};
        cases[3]  = '{"pack16_xor",  VXOR, SEW16, 22, 24,  2, 10, 1'b0};
        cases[4]  = '{"and8",        VAND, SEW8,  13,  5, 18, 27, 1'b0};
        cases[5]  = '{"or16",        VOR,  SEW16, 30, 12, 20, 28, 1'b0};
        cases[6]  = '{"sub8_wrap",   VSUB, SEW8,  64, 16,  0,  8, 1'b0};
        cases[7]  = '{"stall_add8",  VADD, SEW8,  45,  0,  8, 16, 1'b1};
        cases[8]  = '{"stall_sub16", VSUB, SEW16, 27,  3, 14, 22, 1'b1};
        cases[9]  = '{"overlap32",   VADD, SEW32, 12,  6,  6, 20, 1'b0};
        cases[10] = '{"overlap8",    VXOR, SEW8,  21,  9,  9,  1, 1'b1};
    endtask

    initial begin
        void'($urandom(32'hfcc76dde));
        nRST       <= 1'b0;
        cfg_we     <= 1'b0;
        cfg_vl     <= '0;
        cfg_eew    <= SEW8;
        issue      <= 1'b0;
        instr_op   <= VADD;
        instr_vd   <= '0;
        instr_vs1  <= '0;
        instr_vs2  <= '0;
        stall      <= 1'b0;
        host_we    <= 1'b0;
        host_reg   <= '0;
        host_bank  <= '0;
        host_wdata <= '0;
        build_table();
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        foreach (cases[i]) begin
            preload_regs();
            issue_case(cases[i]);
            wait_done(cases[i]);
            apply_model(cases[i]);
            read_back(cases[i].name);
        end
        if (i_vec_unit_top.i_vec_uop_gen.i_vec_unit_props.assert_fails == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Micro-op generator assertions failed");
            $display("Some tests failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// File: project.f
vec_pkg.sv
vec_decode.sv
vec_uop_gen.sv
vec_regfile.sv
vec_lane_alu.sv
vec_unit_top.sv
vec_unit_props.sv
tb_vec_unit.sv
